//--- Makefile
TOP = tb_bif_bctl

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- list.f
src/bctl_pkg.sv
src/bctl_ifs.sv
src/bctl_sync.sv
src/bctl_arbiter.sv
src/bctl_timing.sv
src/bctl_parity.sv
src/bctl_drivers.sv
src/bif_bctl.sv
sim/tb_bif_bctl.sv

//--- sim/tb_bif_bctl.sv
`default_nettype none

module tb_bif_bctl import bctl_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 16;  // Data phase limit given to the DUT
   localparam int WAIT_LIMIT     = 64;  // Longest wait in osc cycles

   // Output selectors for wait_out
   localparam int O_CACT = 0;
   localparam int O_BREF = 1;
   localparam int O_IOX  = 2;
   localparam int O_PERR = 3;

   logic osc;
   logic rst_n;
   logic crq_n, iorq_n, moff_n;                 // CPU side
   logic ibreq_n, refrq_n, isemrq_n, clear_n;  // Outside requests
   logic ibdry_n, ibperr_n;                     // Slave answer
   logic term_n, lperr_n, pa_n, ps_n;
   logic gnt_n, cact_n, bmem_n, bref_n, iod_n, semrq_n;
   logic eadr_n, bapr_n, bdap_n, berror_n;
   logic [2:0] q_n;
   logic parerr_n, rerr_n, ioxerr_n, spea, spes;

   logic [31:0] lfsr = 32'h73124d5a;  // Stimulus generator state

   bif_bctl #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) u_bif_bctl (.*);

   initial begin
      osc = 1'b0;
      forever #10 osc = ~osc;  // 50 MHz
   end

   initial begin
      #200000;  // Whole run limit
      fail_now("Simulation ran past its time limit");
   end

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("Done: errors found");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_now($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_state(input string name, input cyc_state_t exp, input cyc_state_t act);
      if (act !== exp) begin
         fail_now($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_cycle(input string name, input bus_cycle_t exp, input bus_cycle_t act);
      if (act !== exp) begin
         fail_now($sformatf("MISMATCH %s: expected %s, actual %s", name, exp.name(),
                            act.name()));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         fail_now($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
      end
   endtask

   // Galois LFSR, one step per bit taken
   function logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Cycle type as seen on the bus strobes
   function automatic bus_cycle_t decode_cycle();
      if (!bref_n) return CYC_REF;
      if (!gnt_n) return CYC_BUS;
      if (!semrq_n) return CYC_SEM;
      if (!bmem_n) return CYC_MEM;
      if (!iod_n) return CYC_IO;
      return CYC_NONE;
   endfunction

   function automatic logic out_bit(input int sel);
      case (sel)
         O_CACT:  return cact_n;
         O_BREF:  return bref_n;
         O_IOX:   return ioxerr_n;
         default: return parerr_n;
      endcase
   endfunction

   task automatic next_drive();
      @(posedge osc);
      #2;  // Inputs change just after the edge
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge osc);
      #2;
   endtask

   // Samples on falling edges until the output reaches the level
   task automatic wait_out(input int sel, input logic level, input string what);
      int n;
      n = 0;
      @(negedge osc);
      while (out_bit(sel) !== level) begin
         n++;
         if (n > WAIT_LIMIT) begin
            fail_now({"Timed out waiting for ", what});
         end
         @(negedge osc);
      end
   endtask

   task automatic set_request(input bus_cycle_t c, input logic on);
      case (c)
         CYC_REF: refrq_n  = ~on;
         CYC_BUS: ibreq_n  = ~on;
         CYC_SEM: isemrq_n = ~on;
         CYC_MEM: crq_n    = ~on;
         CYC_IO:  iorq_n   = ~on;
         default: ;
      endcase
   endtask

   // Drops the request and lets the granted cycle run out
   task automatic finish_cycle(input bus_cycle_t c);
      next_drive();
      set_request(c, 1'b0);
      if (c == CYC_SEM || c == CYC_MEM || c == CYC_IO) begin
         ibdry_n = 1'b0;  // Slave answers at once
      end
      wait_out(O_CACT, 1'b1, "end of cycle");
      next_drive();
      ibdry_n = 1'b1;
   endtask

   task automatic reset_values();
      @(negedge osc);
      check_bit("reset gnt_n", 1'b1, gnt_n);
      check_bit("reset cact_n", 1'b1, cact_n);
      check_bit("reset bmem_n", 1'b1, bmem_n);
      check_bit("reset bref_n", 1'b1, bref_n);
      check_bit("reset iod_n", 1'b1, iod_n);
      check_bit("reset semrq_n", 1'b1, semrq_n);
      check_bit("reset eadr_n", 1'b1, eadr_n);
      check_bit("reset bapr_n", 1'b1, bapr_n);
      check_bit("reset bdap_n", 1'b1, bdap_n);
      check_bit("reset berror_n", 1'b1, berror_n);
      check_bit("reset parerr_n", 1'b1, parerr_n);
      check_bit("reset rerr_n", 1'b1, rerr_n);
      check_bit("reset ioxerr_n", 1'b1, ioxerr_n);
      check_bit("reset spea", 1'b0, spea);
      check_bit("reset spes", 1'b0, spes);
      check_state("reset q_n", 3'b111, q_n);
      check_cycle("reset cycle", CYC_NONE, decode_cycle());
   endtask

   task automatic cpu_memory_cycle();
      int delay;
      delay = int'(rand_bits(3));  // 0 to 7 wait cycles
      next_drive();
      crq_n = 1'b0;
      wait_out(O_CACT, 1'b0, "memory grant");
      check_bit("mem bmem_n", 1'b0, bmem_n);
      check_bit("mem eadr_n", 1'b0, eadr_n);
      check_state("mem address phase", 3'b111, q_n);
      next_drive();
      crq_n = 1'b1;
      @(negedge osc);
      check_bit("mem eadr_n released", 1'b1, eadr_n);
      check_bit("mem bapr_n", 1'b0, bapr_n);
      check_state("mem address strobe", 3'b110, q_n);
      @(negedge osc);
      check_bit("mem bapr_n released", 1'b1, bapr_n);
      check_bit("mem bdap_n", 1'b0, bdap_n);
      repeat (delay) begin
         @(negedge osc);
         check_bit("mem data phase held", 1'b0, bdap_n);
      end
      next_drive();
      ibdry_n = 1'b0;
      wait_out(O_CACT, 1'b1, "memory cycle end");
      check_bit("mem bdap_n released", 1'b1, bdap_n);
      check_bit("mem ioxerr_n", 1'b1, ioxerr_n);
      next_drive();
      ibdry_n = 1'b1;
      idle_cycles(4);
   endtask

   // Mask bits from 4 down to 0 select refresh, bus, semaphore, memory, I/O
   task automatic priority_order(input string name, input logic [4:0] mask);
      bus_cycle_t order [5];
      bus_cycle_t got;
      int         i;
      order = '{CYC_REF, CYC_BUS, CYC_SEM, CYC_MEM, CYC_IO};
      next_drive();
      for (i = 0; i < 3; i++) begin
         if (mask[4-i]) set_request(order[i], 1'b1);
      end
      next_drive();  // CPU requests skip the synchronizer
      next_drive();
      for (i = 3; i < 5; i++) begin
         if (mask[4-i]) set_request(order[i], 1'b1);
      end
      for (i = 0; i < 5; i++) begin
         if (mask[4-i]) begin
            wait_out(O_CACT, 1'b0, "next grant");
            got = decode_cycle();
            check_cycle(name, order[i], got);
            finish_cycle(got);
         end
      end
      idle_cycles(2);
   endtask

   task automatic memory_blocked();
      next_drive();
      moff_n = 1'b0;
      crq_n  = 1'b0;
      repeat (8) begin
         @(negedge osc);
         check_bit("moff blocks memory", 1'b1, cact_n);
      end
      next_drive();
      crq_n  = 1'b1;
      moff_n = 1'b1;
      idle_cycles(2);
   endtask

   task automatic refresh_length();
      logic [31:0] r;
      int          n;
      next_drive();
      refrq_n = 1'b0;
      wait_out(O_BREF, 1'b0, "refresh grant");
      n = 0;
      while (bref_n === 1'b0) begin
         check_state("refresh count", ~cyc_state_t'(n), q_n);
         n++;
         if (n > WAIT_LIMIT) begin
            fail_now("Refresh cycle never ended");
         end
         next_drive();
         refrq_n = 1'b1;
         r = rand_bits(1);
         ibdry_n = r[0];  // Data ready noise
         @(negedge osc);
      end
      check_count("refresh length", REF_STATES, n);
      next_drive();
      ibdry_n = 1'b1;
      idle_cycles(4);
   endtask

   task automatic timeout_error();
      int n;
      int k;
      next_drive();
      iorq_n = 1'b0;
      wait_out(O_CACT, 1'b0, "I/O grant");
      check_bit("io iod_n", 1'b0, iod_n);
      next_drive();
      iorq_n = 1'b1;
      n = 0;
      k = 0;
      @(negedge osc);
      while (berror_n === 1'b1) begin
         if (bdap_n === 1'b0) n++;  // Data phase cycles so far
         k++;
         if (k > WAIT_LIMIT) begin
            fail_now("No bus error on an unanswered I/O cycle");
         end
         @(negedge osc);
      end
      check_bit("io bdap_n at timeout", 1'b0, bdap_n);
      check_count("io data phase length", TIMEOUT_CYCLES, n + 1);
      @(negedge osc);
      check_bit("io berror_n pulse", 1'b1, berror_n);
      check_bit("io ioxerr_n latched", 1'b0, ioxerr_n);
      check_bit("io cact_n", 1'b1, cact_n);
      next_drive();
      clear_n = 1'b0;
      next_drive();
      clear_n = 1'b1;
      wait_out(O_IOX, 1'b1, "ioxerr_n release");
      idle_cycles(2);
   endtask

   task automatic parity_error();
      next_drive();
      crq_n = 1'b0;
      pa_n  = 1'b0;  // Error on the address side
      wait_out(O_CACT, 1'b0, "memory grant");
      next_drive();
      crq_n    = 1'b1;
      ibdry_n  = 1'b0;
      ibperr_n = 1'b0;
      wait_out(O_CACT, 1'b1, "memory cycle end");
      check_bit("parity parerr_n", 1'b0, parerr_n);
      check_bit("parity rerr_n", 1'b0, rerr_n);
      check_bit("parity spea", 1'b1, spea);
      check_bit("parity spes", 1'b0, spes);
      @(negedge osc);
      check_bit("parity spea pulse", 1'b0, spea);
      check_bit("parity rerr_n held", 1'b0, rerr_n);
      next_drive();
      ibdry_n  = 1'b1;
      ibperr_n = 1'b1;
      pa_n     = 1'b1;
      clear_n  = 1'b0;
      next_drive();
      clear_n = 1'b1;
      wait_out(O_PERR, 1'b1, "parerr_n release");
      check_bit("parity rerr_n cleared", 1'b1, rerr_n);
      // Refresh with every parity input bad
      next_drive();
      refrq_n  = 1'b0;
      ibperr_n = 1'b0;
      lperr_n  = 1'b0;
      ibdry_n  = 1'b0;
      pa_n     = 1'b0;
      ps_n     = 1'b0;
      wait_out(O_BREF, 1'b0, "refresh grant");
      next_drive();
      refrq_n = 1'b1;
      wait_out(O_CACT, 1'b1, "refresh end");
      check_bit("refresh parerr_n", 1'b1, parerr_n);
      check_bit("refresh rerr_n", 1'b1, rerr_n);
      check_bit("refresh spea", 1'b0, spea);
      check_bit("refresh spes", 1'b0, spes);
      next_drive();
      ibperr_n = 1'b1;
      lperr_n  = 1'b1;
      ibdry_n  = 1'b1;
      pa_n     = 1'b1;
      ps_n     = 1'b1;
      idle_cycles(4);
   endtask

   initial begin
      logic [31:0] r;
      logic [4:0]  mask;
      rst_n    = 1'b0;
      crq_n    = 1'b1;
      iorq_n   = 1'b1;
      moff_n   = 1'b1;  // Memory enabled
      ibreq_n  = 1'b1;
      refrq_n  = 1'b1;
      isemrq_n = 1'b1;
      ibdry_n  = 1'b1;
      ibperr_n = 1'b1;
      clear_n  = 1'b1;
      term_n   = 1'b1;
      lperr_n  = 1'b1;
      pa_n     = 1'b1;
      ps_n     = 1'b1;
      repeat (8) @(posedge osc);
      #2;
      rst_n = 1'b1;
      reset_values();
      cpu_memory_cycle();
      priority_order("priority all", 5'b11111);
      repeat (3) begin
         r = rand_bits(5);
         mask = (r[4:0] == 5'b0) ? 5'b00001 : r[4:0];  // At least one request
         priority_order("priority mix", mask);
      end
      memory_blocked();
      refresh_length();
      timeout_error();
      parity_error();
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- src/bctl_arbiter.sv
`default_nettype none

module bctl_arbiter import bctl_pkg::*; (
   input  wire logic osc,
   input  wire logic rst_n,
   input  wire logic crq_n,   // CPU memory request
   input  wire logic iorq_n,  // CPU I/O request
   input  wire logic moff_n,  // Low blocks CPU memory cycles
   bctl_sync_if.arb  sync,
   bctl_cycle_if.arb cyc
);

   bus_cycle_t next_cycle;  // Winner of this cycle's requests
   logic       mem_req;     // CPU memory request, qualified

   assign mem_req = ~crq_n & moff_n;

   // Fixed priority, refresh always wins
   always_comb begin
      if (sync.refrq) begin
         next_cycle = CYC_REF;
      end else if (sync.breq) begin
         next_cycle = CYC_BUS;   // Outside master next
      end else if (sync.semrq) begin
         next_cycle = CYC_SEM;
      end else if (mem_req) begin
         next_cycle = CYC_MEM;
      end else if (!iorq_n) begin
         next_cycle = CYC_IO;    // Lowest priority
      end else begin
         next_cycle = CYC_NONE;
      end
   end

   always_ff @(posedge osc) begin
      if (!rst_n) begin
         cyc.cycle  <= CYC_NONE;
         cyc.active <= 1'b0;
         cyc.start  <= 1'b0;
      end else begin
         cyc.start <= 1'b0;  // Single cycle pulse
         if (cyc.active) begin
            if (cyc.done) begin
               cyc.active <= 1'b0;  // Free the bus next cycle
               cyc.cycle  <= CYC_NONE;
            end
         end else if (next_cycle != CYC_NONE) begin
            cyc.cycle  <= next_cycle;  // Hold type for the whole grant
            cyc.active <= 1'b1;
            cyc.start  <= 1'b1;
         end
      end
   end

   // Pending levels simply wait here while a grant runs,
   // nothing is queued and nothing is lost

endmodule

`default_nettype wire

//--- src/bctl_drivers.sv
`default_nettype none

module bctl_drivers import bctl_pkg::*; (
   bctl_cycle_if.mon  cyc,
   output logic       gnt_n,
   output logic       cact_n,
   output logic       bmem_n,
   output logic       bref_n,
   output logic       iod_n,
   output logic       semrq_n,
   output logic       eadr_n,
   output logic       bapr_n,
   output logic       bdap_n,
   output logic       berror_n,
   output cyc_state_t q_n
);

   logic own;  // We drive the bus strobes

   assign own = cyc.active && (cyc.cycle != CYC_BUS);  // Outside master drives its own

   assign cact_n  = ~cyc.active;
   assign gnt_n   = ~(cyc.active && cyc.cycle == CYC_BUS);
   assign bmem_n  = ~(cyc.active && (cyc.cycle == CYC_MEM || cyc.cycle == CYC_SEM));
   assign bref_n  = ~(cyc.active && cyc.cycle == CYC_REF);
   assign iod_n   = ~(cyc.active && cyc.cycle == CYC_IO);
   assign semrq_n = ~(cyc.active && cyc.cycle == CYC_SEM);

   // Strobe order follows the state count
   assign eadr_n = ~(own && cyc.state == 3'd0);  // Address out
   assign bapr_n = ~(own && cyc.state == 3'd1);  // Address strobe
   assign bdap_n = ~(own && cyc.state >= 3'd2);  // Data phase

   assign berror_n = ~cyc.tmo;    // Bus error on timeout
   assign q_n      = ~cyc.state;  // Idle count reads 111

endmodule

`default_nettype wire

//--- src/bctl_ifs.sv
`default_nettype none

// Synchronized outside requests, all active high
interface bctl_sync_if ();
   logic breq;       // Bus master request
   logic refrq;      // Refresh request
   logic semrq;      // Semaphore request
   logic bdry;       // Bus data ready level
   logic bdry_rise;  // One-cycle pulse on data ready assertion
   logic bperr;      // Bus parity error
   logic clear;      // Bus clear, drops latched errors

   modport src (output breq, refrq, semrq, bdry, bdry_rise, bperr, clear);
   modport arb (input breq, refrq, semrq);
   modport tim (input breq, bdry_rise);
   modport par (input bperr, bdry, clear);
endinterface

// Active bus cycle shared by arbiter, sequencer and monitors
interface bctl_cycle_if import bctl_pkg::*; ();
   bus_cycle_t cycle;   // Granted cycle type
   logic       start;   // First cycle of a grant
   cyc_state_t state;   // Sequencer count
   logic       done;    // Last cycle of a grant
   logic       tmo;     // Data phase timed out
   logic       active;  // Grant in progress

   modport arb (output cycle, start, active, input done);
   modport tim (input cycle, start, active, output state, done, tmo);
   modport mon (input cycle, start, state, done, tmo, active);
endinterface

`default_nettype wire

//--- src/bctl_parity.sv
`default_nettype none

module bctl_parity import bctl_pkg::*; (
   input  wire logic  osc,
   input  wire logic  rst_n,
   input  wire logic  lperr_n,  // Local memory parity error
   input  wire logic  pa_n,     // Error belongs to address side
   input  wire logic  ps_n,     // Error belongs to slave side
   bctl_sync_if.par   sync,
   bctl_cycle_if.mon  cyc,
   output logic       parerr_n,
   output logic       rerr_n,
   output logic       ioxerr_n,
   output logic       spea,
   output logic       spes
);

   logic bperr_seen;  // Bus parity error during data ready
   logic perr_now;    // Any parity error at the end of the cycle
   logic set_rerr;    // First latch of rerr_n

   // Capture bus parity while data ready is up
   always_ff @(posedge osc) begin
      if (!rst_n || cyc.start) begin
         bperr_seen <= 1'b0;  // Fresh for each grant
      end else if (cyc.active && sync.bdry && sync.bperr) begin
         bperr_seen <= 1'b1;
      end
   end

   assign perr_now = bperr_seen || (sync.bdry && sync.bperr) || !lperr_n;
   assign set_rerr = cyc.done && (cyc.cycle != CYC_REF) && perr_now;  // Refresh exempt

   always_ff @(posedge osc) begin
      if (!rst_n || sync.clear) begin
         parerr_n <= 1'b1;  // Bus clear drops all latches
         rerr_n   <= 1'b1;
         ioxerr_n <= 1'b1;
      end else begin
         if (set_rerr) begin
            parerr_n <= 1'b0;
            rerr_n   <= 1'b0;
         end
         if (cyc.tmo) begin
            ioxerr_n <= 1'b0;  // No answer from I/O or memory
         end
      end
   end

   // Status strobes only on the edge that latches rerr_n
   always_ff @(posedge osc) begin
      if (!rst_n) begin
         spea <= 1'b0;
         spes <= 1'b0;
      end else begin
         spea <= set_rerr && rerr_n && !sync.clear && !pa_n;
         spes <= set_rerr && rerr_n && !sync.clear && !ps_n;
      end
   end

endmodule

`default_nettype wire

//--- src/bctl_pkg.sv
`default_nettype none

package bctl_pkg;

   // Kind of bus cycle owned by the control block
   typedef enum logic [2:0] {
      CYC_NONE = 3'd0,   // Idle, no cycle granted
      CYC_REF  = 3'd1,   // Memory refresh
      CYC_BUS  = 3'd2,   // External bus master
      CYC_SEM  = 3'd3,   // Semaphore access
      CYC_MEM  = 3'd4,   // CPU memory access
      CYC_IO   = 3'd5    // CPU I/O access
   } bus_cycle_t;

   // Sequencer state count, seen inverted on q_n
   typedef logic [2:0] cyc_state_t;

   // Refresh cycle length in osc cycles
   localparam int REF_STATES = 6;

endpackage

`default_nettype wire

//--- src/bctl_sync.sv
`default_nettype none

module bctl_sync (
   input  wire logic osc,
   input  wire logic rst_n,
   input  wire logic ibreq_n,
   input  wire logic refrq_n,
   input  wire logic isemrq_n,
   input  wire logic ibdry_n,
   input  wire logic ibperr_n,
   input  wire logic clear_n,
   bctl_sync_if.src  sync
);

   // Bit positions in the sampled vector
   localparam int B_BREQ  = 5;
   localparam int B_REFRQ = 4;
   localparam int B_SEMRQ = 3;
   localparam int B_BDRY  = 2;
   localparam int B_BPERR = 1;
   localparam int B_CLEAR = 0;

   logic [5:0] raw;      // Inverted pins, active high
   logic [5:0] stage1;   // First flop, may go metastable
   logic [5:0] stage2;   // Second flop, safe to use
   logic       bdry_d3;  // Extra data ready stage for edge detect

   assign raw = ~{ibreq_n, refrq_n, isemrq_n, ibdry_n, ibperr_n, clear_n};

   always_ff @(posedge osc) begin
      if (!rst_n) begin
         stage1  <= '0;  // All requests inactive
         stage2  <= '0;
         bdry_d3 <= 1'b0;
      end else begin
         stage1  <= raw;
         stage2  <= stage1;
         bdry_d3 <= stage2[B_BDRY];  // Delayed copy of data ready
      end
   end

   assign sync.breq      = stage2[B_BREQ];
   assign sync.refrq     = stage2[B_REFRQ];
   assign sync.semrq     = stage2[B_SEMRQ];
   assign sync.bdry      = stage2[B_BDRY];
   assign sync.bperr     = stage2[B_BPERR];
   assign sync.clear     = stage2[B_CLEAR];
   assign sync.bdry_rise = stage2[B_BDRY] & ~bdry_d3;  // New data ready only

endmodule

`default_nettype wire

//--- src/bctl_timing.sv
`default_nettype none

module bctl_timing import bctl_pkg::*; #(
   parameter int TIMEOUT_CYCLES = 16
) (
   input  wire logic osc,
   input  wire logic rst_n,
   input  wire logic term_n,  // CPU terminates the cycle
   bctl_sync_if.tim  sync,
   bctl_cycle_if.tim cyc
);

   localparam int TW = $clog2(TIMEOUT_CYCLES + 1);  // Timeout counter width

   localparam cyc_state_t ST_DATA = cyc_state_t'(2);               // First data state
   localparam cyc_state_t ST_LAST = cyc_state_t'(7);               // Saturation point
   localparam cyc_state_t ST_REF  = cyc_state_t'(REF_STATES - 1);  // Last refresh state

   logic [TW-1:0] tmo_cnt;   // Data phase cycles so far
   logic          own_cyc;   // Cycle that waits for data ready
   logic          data_ph;   // Data phase of such a cycle
   logic          end_ref;   // Refresh has run its length
   logic          end_bus;   // Outside master let go
   logic          end_rdy;   // Slave answered
   logic          end_term;  // CPU cut the cycle short

   assign own_cyc = (cyc.cycle == CYC_SEM) || (cyc.cycle == CYC_MEM) ||
                    (cyc.cycle == CYC_IO);
   assign data_ph = cyc.active && own_cyc && (cyc.state >= ST_DATA);

   assign end_ref  = (cyc.cycle == CYC_REF) && (cyc.state == ST_REF);  // bdry ignored
   assign end_bus  = (cyc.cycle == CYC_BUS) && !sync.breq;
   assign end_rdy  = data_ph && sync.bdry_rise;
   assign end_term = !term_n && (cyc.cycle != CYC_REF);

   // Timeout only when no data ready arrives in the same cycle
   assign cyc.tmo  = data_ph && !sync.bdry_rise &&
                     (tmo_cnt == TW'(TIMEOUT_CYCLES - 1));

   assign cyc.done = cyc.active &&
                     (end_ref || end_bus || end_rdy || end_term || cyc.tmo);

   // State count, 0 address, 1 strobe, 2 and up data
   always_ff @(posedge osc) begin
      if (!rst_n) begin
         cyc.state <= '0;  // q_n reads all ones
      end else if (!cyc.active || cyc.done) begin
         cyc.state <= '0;  // Ready for next start
      end else if (cyc.state != ST_LAST) begin
         cyc.state <= cyc.state + 3'd1;  // Saturates at 7
      end
   end

   always_ff @(posedge osc) begin
      if (!rst_n) begin
         tmo_cnt <= '0;
      end else if (!data_ph) begin
         tmo_cnt <= '0;  // Restart for each grant
      end else if (tmo_cnt != TW'(TIMEOUT_CYCLES - 1)) begin
         tmo_cnt <= tmo_cnt + TW'(1);
      end
   end

endmodule

`default_nettype wire

//--- src/bif_bctl.sv
`default_nettype none

module bif_bctl #(
   parameter int TIMEOUT_CYCLES = 16  // Data phase limit
) (
   input  wire logic osc,
   input  wire logic rst_n,
   input  wire logic crq_n,
   input  wire logic iorq_n,
   input  wire logic moff_n,
   input  wire logic ibreq_n,
   input  wire logic refrq_n,
   input  wire logic isemrq_n,
   input  wire logic ibdry_n,
   input  wire logic ibperr_n,
   input  wire logic clear_n,
   input  wire logic term_n,
   input  wire logic lperr_n,
   input  wire logic pa_n,
   input  wire logic ps_n,
   output logic       gnt_n,
   output logic       cact_n,
   output logic       bmem_n,
   output logic       bref_n,
   output logic       iod_n,
   output logic       semrq_n,
   output logic       eadr_n,
   output logic       bapr_n,
   output logic       bdap_n,
   output logic       berror_n,
   output logic [2:0] q_n,
   output logic       parerr_n,
   output logic       rerr_n,
   output logic       ioxerr_n,
   output logic       spea,
   output logic       spes
);

   bctl_sync_if  sync ();  // Synchronized outside inputs
   bctl_cycle_if cyc ();   // Active grant

   bctl_sync u_sync (
      .osc      (osc),
      .rst_n    (rst_n),
      .ibreq_n  (ibreq_n),
      .refrq_n  (refrq_n),
      .isemrq_n (isemrq_n),
      .ibdry_n  (ibdry_n),
      .ibperr_n (ibperr_n),
      .clear_n  (clear_n),
      .sync     (sync.src)
   );

   bctl_arbiter u_arbiter (
      .osc    (osc),
      .rst_n  (rst_n),
      .crq_n  (crq_n),
      .iorq_n (iorq_n),
      .moff_n (moff_n),
      .sync   (sync.arb),
      .cyc    (cyc.arb)
   );

   bctl_timing #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) u_timing (
      .osc    (osc),
      .rst_n  (rst_n),
      .term_n (term_n),
      .sync   (sync.tim),
      .cyc    (cyc.tim)
   );

   bctl_parity u_parity (
      .osc      (osc),
      .rst_n    (rst_n),
      .lperr_n  (lperr_n),
      .pa_n     (pa_n),
      .ps_n     (ps_n),
      .sync     (sync.par),
      .cyc      (cyc.mon),
      .parerr_n (parerr_n),
      .rerr_n   (rerr_n),
      .ioxerr_n (ioxerr_n),
      .spea     (spea),
      .spes     (spes)
   );

   bctl_drivers u_drivers (
      .cyc      (cyc.mon),
      .gnt_n    (gnt_n),
      .cact_n   (cact_n),
      .bmem_n   (bmem_n),
      .bref_n   (bref_n),
      .iod_n    (iod_n),
      .semrq_n  (semrq_n),
      .eadr_n   (eadr_n),
      .bapr_n   (bapr_n),
      .bdap_n   (bdap_n),
      .berror_n (berror_n),
      .q_n      (q_n)
   );

endmodule

`default_nettype wire
